//--- run.sh
#!/usr/bin/env bash
# Build the sorter testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --top-module tb_qs_srt -f src.f -o Vtb_qs_srt > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_qs_srt > sim.log 2>&1 ; cat sim.log
[ -s sim.log ] && ! grep -q "Simulation finished: FAIL" sim.log \
  && { echo "Result: pass"; exit 0; } \
  || { echo "Result: fail"; exit 1; }

//--- source/qs_srt.sv
////////////////////
// Sorter top level
////////////////////
`timescale 1ns/1ps
`default_nettype none

module qs_srt #(
  parameter int STACK_N = qs_srt_pkg::STACK_N_DEFAULT
) (
  input  logic              clk,
  input  logic              reset,
  // Bank handshake
  input  logic              bank_ready,
  input  qs_srt_pkg::len_t  bank_n,
  output logic              bank_done,
  // Bank memory
  output logic              rd_en,
  output qs_srt_pkg::addr_t rd_addr,
  input  qs_srt_pkg::w_t    rd_data,
  output logic              wr_en,
  output qs_srt_pkg::addr_t wr_addr,
  output qs_srt_pkg::w_t    wr_data
);

  qs_srt_fetch_if fe_if ();
  qs_srt_rf_if    rf_if ();
  qs_srt_stack_if st_if ();

  qs_srt_fetch u_qs_srt_fetch (
    .clk   (clk),
    .reset (reset),
    .fe    (fe_if)
  );

  qs_srt_execute u_qs_srt_execute (
    .clk        (clk),
    .reset      (reset),
    .fe         (fe_if),
    .rf         (rf_if),
    .st         (st_if),
    .bank_ready (bank_ready),
    .bank_n     (bank_n),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .bank_done  (bank_done)
  );

  qs_srt_rf u_qs_srt_rf (
    .clk   (clk),
    .reset (reset),
    .rf    (rf_if)
  );

  qs_srt_stack #(
    .STACK_N (STACK_N)
  ) u_qs_srt_stack (
    .clk   (clk),
    .reset (reset),
    .st    (st_if)
  );

endmodule

`default_nettype wire

//--- source/qs_srt_decoder.sv
////////////////////
// Instruction decoder
////////////////////
`timescale 1ns/1ps
`default_nettype none

module qs_srt_decoder (
  input  qs_srt_pkg::inst_t  inst,
  output qs_srt_pkg::ucode_t ucode
);
  import qs_srt_pkg::*;

  inst_fmt_t f;

  assign f = inst_fmt_t'(inst);

  always_comb begin
    // Fields common to every opcode
    ucode         = '0;
    ucode.src0    = f.src0;
    ucode.src1    = f.src1;
    ucode.dst     = f.dst;
    ucode.imm     = f.imm;
    ucode.target  = pc_t'(f.imm);
    ucode.cc      = f.cc;
    ucode.has_imm = (f.bsel == B_IMM);
    ucode.has_n   = (f.bsel == B_N);

    case (f.op)
      ADD: begin
        ucode.dst_en  = 1'b1;
        ucode.flag_en = 1'b1;
      end
      // A minus B as A plus not B plus one
      SUB: begin
        ucode.dst_en  = 1'b1;
        ucode.flag_en = 1'b1;
        ucode.inv     = 1'b1;
        ucode.cin     = 1'b1;
      end
      MOV: begin
        ucode.dst_en    = 1'b1;
        ucode.src0_zero = 1'b1;
      end
      LD: begin
        ucode.dst_en  = 1'b1;
        ucode.is_load = 1'b1;
      end
      ST:    ucode.is_store = 1'b1;
      JMP:   ucode.is_jump  = 1'b1;
      // Link address goes to the fixed link register
      CALL: begin
        ucode.is_call = 1'b1;
        ucode.dst_en  = 1'b1;
        ucode.dst     = LINK_REG;
      end
      RET:   ucode.is_ret   = 1'b1;
      PUSH:  ucode.is_push  = 1'b1;
      POP: begin
        ucode.is_pop = 1'b1;
        ucode.dst_en = 1'b1;
      end
      AWAIT: ucode.is_await = 1'b1;
      DONE:  ucode.is_done  = 1'b1;
      // Illegal opcode runs as a no-op
      default: ucode = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/qs_srt_execute.sv
////////////////////
// Execute and commit stage with datapath and bank access
////////////////////
`timescale 1ns/1ps
`default_nettype none

module qs_srt_execute (
  input  logic                  clk,
  input  logic                  reset,
  qs_srt_fetch_if.execute       fe,
  qs_srt_rf_if.source           rf,
  qs_srt_stack_if.source        st,
  input  logic                  bank_ready,
  input  qs_srt_pkg::len_t      bank_n,
  output logic                  rd_en,
  output qs_srt_pkg::addr_t     rd_addr,
  input  qs_srt_pkg::w_t        rd_data,
  output logic                  wr_en,
  output qs_srt_pkg::addr_t     wr_addr,
  output qs_srt_pkg::w_t        wr_data,
  output logic                  bank_done
);
  import qs_srt_pkg::*;

  logic   xa_vld_r;
  pc_t    xa_pc_r;
  inst_t  xa_inst_r;
  ucode_t xa_ucode;
  logic   xa_ld_pend_r;
  logic   xa_stall;
  logic   xa_kill;
  logic   xa_commit;
  logic   xa_cc_hit;
  logic   xa_fwd0;
  logic   xa_fwd1;
  w_t     xa_op_a;
  w_t     xa_op_b;
  w_t     xa_alu_b;
  w_t     xa_alu_y;
  logic   xa_alu_cout;
  w_t     xa_wb_data;
  logic   xa_replay;
  flags_t ar_flags_r;
  logic   ca_rf_wen_r;
  reg_t   ca_rf_wa_r;
  w_t     ca_rf_wdata_r;
  logic   ca_replay_r;
  pc_t    ca_replay_pc_r;

  qs_srt_decoder u_qs_srt_decoder (
    .inst  (xa_inst_r),
    .ucode (xa_ucode)
  );

  // Await holds for the bank, a load holds one cycle for its data
  assign xa_kill   = ca_replay_r;
  assign xa_stall  = xa_vld_r && ((xa_ucode.is_await && !bank_ready) ||
                                  (xa_ucode.is_load && !xa_ld_pend_r));
  assign xa_commit = xa_vld_r && !xa_stall && !xa_kill;

  assign fe.stall     = xa_stall;
  assign fe.replay    = ca_replay_r;
  assign fe.replay_pc = ca_replay_pc_r;

  always_ff @(posedge clk) begin
    if (reset || xa_kill) begin
      xa_vld_r <= 1'b0;
    end else if (!xa_stall) begin
      xa_vld_r <= fe.vld;
    end
  end

  always_ff @(posedge clk) begin
    if (!xa_stall) begin
      xa_pc_r   <= fe.pc;
      xa_inst_r <= fe.inst;
    end
  end

  // Register reads, forwarded from the commit register
  assign rf.ra0  = xa_ucode.src0;
  assign rf.ra1  = xa_ucode.src1;
  assign xa_fwd0 = ca_rf_wen_r && (ca_rf_wa_r == xa_ucode.src0);
  assign xa_fwd1 = ca_rf_wen_r && (ca_rf_wa_r == xa_ucode.src1);

  always_comb begin
    // Operand A
    if (xa_ucode.src0_zero) begin
      xa_op_a = '0;
    end else if (xa_fwd0) begin
      xa_op_a = ca_rf_wdata_r;
    end else begin
      xa_op_a = rf.rd0;
    end

    // Operand B
    if (xa_ucode.has_n) begin
      xa_op_b = w_t'(bank_n);
    end else if (xa_ucode.has_imm) begin
      xa_op_b = w_t'(xa_ucode.imm);
    end else if (xa_fwd1) begin
      xa_op_b = ca_rf_wdata_r;
    end else begin
      xa_op_b = rf.rd1;
    end

    // Adder
    xa_alu_b = xa_ucode.inv ? ~xa_op_b : xa_op_b;
    {xa_alu_cout, xa_alu_y} = {1'b0, xa_op_a} + {1'b0, xa_alu_b} + {16'b0, xa_ucode.cin};

    // Unsigned compare, carry set means no borrow
    case (xa_ucode.cc)
      EQ:      xa_cc_hit = ar_flags_r.z;
      GT:      xa_cc_hit = ar_flags_r.c && !ar_flags_r.z;
      LE:      xa_cc_hit = !ar_flags_r.c || ar_flags_r.z;
      default: xa_cc_hit = 1'b1;
    endcase

    // Writeback source
    if (xa_ucode.is_pop) begin
      xa_wb_data = st.empty ? '0 : st.head;
    end else if (xa_ucode.is_call) begin
      xa_wb_data = w_t'(xa_pc_r) + w_t'(1);
    end else if (xa_ucode.is_load) begin
      xa_wb_data = rd_data;
    end else begin
      xa_wb_data = xa_alu_y;
    end

    xa_replay = xa_commit && ((xa_ucode.is_jump && xa_cc_hit) ||
                              xa_ucode.is_call || xa_ucode.is_ret);
  end

  // Control state of the commit stage
  always_ff @(posedge clk) begin
    if (reset) begin
      ar_flags_r   <= '0;
      ca_rf_wen_r  <= 1'b0;
      ca_replay_r  <= 1'b0;
      xa_ld_pend_r <= 1'b0;
      wr_en        <= 1'b0;
      bank_done    <= 1'b0;
    end else begin
      if (xa_commit && xa_ucode.flag_en) begin
        ar_flags_r <= '{c: xa_alu_cout, n: xa_alu_y[15], z: (xa_alu_y == '0)};
      end
      ca_rf_wen_r  <= xa_commit && xa_ucode.dst_en;
      ca_replay_r  <= xa_replay;
      xa_ld_pend_r <= rd_en;
      wr_en        <= xa_commit && xa_ucode.is_store;
      bank_done    <= xa_commit && xa_ucode.is_done;
    end
  end

  always_ff @(posedge clk) begin
    ca_rf_wa_r    <= xa_ucode.dst;
    ca_rf_wdata_r <= xa_wb_data;
    wr_addr       <= addr_t'(xa_op_a);
    wr_data       <= xa_op_b;
    // Return target comes from the link register
    if (xa_replay) begin
      ca_replay_pc_r <= xa_ucode.is_ret ? pc_t'(xa_op_b) : xa_ucode.target;
    end
  end

  assign rf.wen   = ca_rf_wen_r;
  assign rf.wa    = ca_rf_wa_r;
  assign rf.wdata = ca_rf_wdata_r;

  // Stack command straight from commit
  assign st.vld      = xa_commit && ((xa_ucode.is_push && !st.full) || xa_ucode.is_pop);
  assign st.push     = xa_ucode.is_push;
  assign st.push_dat = xa_op_b;

  // Read issued in the first load cycle only
  assign rd_en   = xa_vld_r && xa_ucode.is_load && !xa_ld_pend_r && !xa_kill;
  assign rd_addr = addr_t'(xa_op_a);

endmodule

`default_nettype wire

//--- source/qs_srt_fetch.sv
////////////////////
// Fetch stage and microcode ROM with the sort program
////////////////////
`timescale 1ns/1ps
`default_nettype none

module qs_srt_fetch (
  input  logic          clk,
  input  logic          reset,
  qs_srt_fetch_if.fetch fe
);
  import qs_srt_pkg::*;

  // Register roles in the sort program
  localparam reg_t R_0    = 3'd0;
  localparam reg_t R_LIM  = 3'd1;
  localparam reg_t R_J    = 3'd2;
  localparam reg_t R_T    = 3'd3;
  localparam reg_t R_A    = 3'd4;
  localparam reg_t R_B    = 3'd5;
  localparam reg_t R_J1   = 3'd6;
  localparam reg_t R_LINK = LINK_REG;

  // Program labels
  localparam logic [IMM_W-1:0] L_AWAIT = 7'd0;
  localparam logic [IMM_W-1:0] L_OUTER = 7'd2;
  localparam logic [IMM_W-1:0] L_INNER = 7'd5;
  localparam logic [IMM_W-1:0] L_FIN   = 7'd10;
  localparam logic [IMM_W-1:0] L_CAS   = 7'd12;
  localparam logic [IMM_W-1:0] L_SKIP  = 7'd22;

  logic  vld_r;
  pc_t   pc_r;
  inst_t rom_inst;

  // Pack fields into a raw word
  function automatic inst_t asm_op(op_t op, cc_t cc, reg_t dst, reg_t s0, reg_t s1,
                                   logic [1:0] bsel, logic [IMM_W-1:0] imm);
    inst_fmt_t f;
    f = '{op: op, cc: cc, dst: dst, src0: s0, src1: s1, bsel: bsel, imm: imm};
    return inst_t'(f);
  endfunction

  // Bubble sort of words 0 to n-1
  always_comb begin
    case (pc_r)
      // Wait for a bank then lim = n
      6'd0:  rom_inst = asm_op(AWAIT, ALWAYS, R_0, R_0, R_0, B_REG, '0);
      6'd1:  rom_inst = asm_op(MOV, ALWAYS, R_LIM, R_0, R_0, B_N, '0);
      // Outer loop, exit once lim reaches zero or below
      6'd2:  rom_inst = asm_op(SUB, ALWAYS, R_LIM, R_LIM, R_0, B_IMM, 7'd1);
      6'd3:  rom_inst = asm_op(JMP, LE, R_0, R_0, R_0, B_REG, L_FIN);
      6'd4:  rom_inst = asm_op(MOV, ALWAYS, R_J, R_0, R_0, B_IMM, 7'd0);
      // Inner loop over j below lim
      6'd5:  rom_inst = asm_op(CALL, ALWAYS, R_0, R_0, R_0, B_REG, L_CAS);
      6'd6:  rom_inst = asm_op(ADD, ALWAYS, R_J, R_J, R_0, B_IMM, 7'd1);
      6'd7:  rom_inst = asm_op(SUB, ALWAYS, R_T, R_LIM, R_J, B_REG, '0);
      6'd8:  rom_inst = asm_op(JMP, GT, R_0, R_0, R_0, B_REG, L_INNER);
      6'd9:  rom_inst = asm_op(JMP, ALWAYS, R_0, R_0, R_0, B_REG, L_OUTER);
      // Report and go back for the next bank
      6'd10: rom_inst = asm_op(DONE, ALWAYS, R_0, R_0, R_0, B_REG, '0);
      6'd11: rom_inst = asm_op(JMP, ALWAYS, R_0, R_0, R_0, B_REG, L_AWAIT);
      // Compare and swap words j and j+1
      6'd12: rom_inst = asm_op(PUSH, ALWAYS, R_0, R_0, R_A, B_REG, '0);
      6'd13: rom_inst = asm_op(PUSH, ALWAYS, R_0, R_0, R_B, B_REG, '0);
      6'd14: rom_inst = asm_op(PUSH, ALWAYS, R_0, R_0, R_J1, B_REG, '0);
      6'd15: rom_inst = asm_op(ADD, ALWAYS, R_J1, R_J, R_0, B_IMM, 7'd1);
      6'd16: rom_inst = asm_op(LD, ALWAYS, R_A, R_J, R_0, B_REG, '0);
      6'd17: rom_inst = asm_op(LD, ALWAYS, R_B, R_J1, R_0, B_REG, '0);
      6'd18: rom_inst = asm_op(SUB, ALWAYS, R_T, R_A, R_B, B_REG, '0);
      6'd19: rom_inst = asm_op(JMP, LE, R_0, R_0, R_0, B_REG, L_SKIP);
      6'd20: rom_inst = asm_op(ST, ALWAYS, R_0, R_J, R_B, B_REG, '0);
      6'd21: rom_inst = asm_op(ST, ALWAYS, R_0, R_J1, R_A, B_REG, '0);
      // Restore in reverse order
      6'd22: rom_inst = asm_op(POP, ALWAYS, R_J1, R_0, R_0, B_REG, '0);
      6'd23: rom_inst = asm_op(POP, ALWAYS, R_B, R_0, R_0, B_REG, '0);
      6'd24: rom_inst = asm_op(POP, ALWAYS, R_A, R_0, R_0, B_REG, '0);
      6'd25: rom_inst = asm_op(RET, ALWAYS, R_0, R_0, R_LINK, B_REG, '0);
      // Stray pc falls back to await
      default: rom_inst = asm_op(JMP, ALWAYS, R_0, R_0, R_0, B_REG, L_AWAIT);
    endcase
  end

  // Valid from the second cycle after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      vld_r <= 1'b0;
      pc_r  <= '0;
    end else begin
      vld_r <= 1'b1;
      // Redirect wins over advance
      if (fe.replay) begin
        pc_r <= fe.replay_pc;
      end else if (vld_r && !fe.stall) begin
        pc_r <= pc_r + pc_t'(1);
      end
    end
  end

  assign fe.vld  = vld_r;
  assign fe.pc   = pc_r;
  assign fe.inst = rom_inst;

endmodule

`default_nettype wire

//--- source/qs_srt_if.sv
////////////////////
// Fetch, register file and stack interfaces
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface qs_srt_fetch_if;
  import qs_srt_pkg::*;

  logic  vld;
  pc_t   pc;
  inst_t inst;
  // Back-pressure and redirect from execute
  logic  stall;
  logic  replay;
  pc_t   replay_pc;

  modport fetch   (output vld, pc, inst, input stall, replay, replay_pc);
  modport execute (input vld, pc, inst, output stall, replay, replay_pc);
endinterface

interface qs_srt_rf_if;
  import qs_srt_pkg::*;

  reg_t ra0;
  reg_t ra1;
  w_t   rd0;
  w_t   rd1;
  logic wen;
  reg_t wa;
  w_t   wdata;

  modport source (output ra0, ra1, wen, wa, wdata, input rd0, rd1);
  modport target (input ra0, ra1, wen, wa, wdata, output rd0, rd1);
endinterface

interface qs_srt_stack_if;
  import qs_srt_pkg::*;

  // Command with push high for push and low for pop
  logic vld;
  logic push;
  w_t   push_dat;
  w_t   head;
  logic empty;
  logic full;

  modport source (output vld, push, push_dat, input head, empty, full);
  modport target (input vld, push, push_dat, output head, empty, full);
endinterface

`default_nettype wire

//--- source/qs_srt_pkg.sv
////////////////////
// Shared types, opcodes, instruction layout and decoded microcode
////////////////////
`default_nettype none

package qs_srt_pkg;

  // Datapath widths
  typedef logic [15:0] w_t;
  typedef logic [7:0]  addr_t;
  typedef logic [8:0]  len_t;
  typedef logic [5:0]  pc_t;
  typedef logic [2:0]  reg_t;
  typedef logic [23:0] inst_t;

  // Immediate field width in the instruction word
  localparam int IMM_W = 7;

  // Default hardware stack depth
  localparam int STACK_N_DEFAULT = 16;

  // Link register written by call
  localparam reg_t LINK_REG = 3'd7;

  // Operand B source select
  localparam logic [1:0] B_REG = 2'd0;
  localparam logic [1:0] B_IMM = 2'd1;
  localparam logic [1:0] B_N   = 2'd2;

  typedef enum logic [1:0] {
    ALWAYS = 2'd0,
    EQ     = 2'd1,
    GT     = 2'd2,
    LE     = 2'd3
  } cc_t;

  // Codes 12 to 15 are illegal and run as a no-op
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    MOV   = 4'd2,
    LD    = 4'd3,
    ST    = 4'd4,
    JMP   = 4'd5,
    CALL  = 4'd6,
    RET   = 4'd7,
    PUSH  = 4'd8,
    POP   = 4'd9,
    AWAIT = 4'd10,
    DONE  = 4'd11
  } op_t;

  // Field layout of a raw microcode word
  typedef struct packed {
    op_t              op;
    cc_t              cc;
    reg_t             dst;
    reg_t             src0;
    reg_t             src1;
    logic [1:0]       bsel;
    logic [IMM_W-1:0] imm;
  } inst_fmt_t;

  typedef struct packed {
    reg_t             src0;
    reg_t             src1;
    reg_t             dst;
    logic             dst_en;
    logic             flag_en;
    logic             src0_zero;
    logic             has_imm;
    logic             has_n;
    logic [IMM_W-1:0] imm;
    pc_t              target;
    cc_t              cc;
    logic             cin;
    logic             inv;
    logic             is_jump;
    logic             is_call;
    logic             is_ret;
    logic             is_push;
    logic             is_pop;
    logic             is_load;
    logic             is_store;
    logic             is_await;
    logic             is_done;
  } ucode_t;

  // Carry, negative and zero
  typedef struct packed {
    logic c;
    logic n;
    logic z;
  } flags_t;

endpackage

`default_nettype wire

//--- source/qs_srt_rf.sv
////////////////////
// Register file, 2 read ports and 1 write port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module qs_srt_rf (
  input  logic         clk,
  input  logic         reset,
  qs_srt_rf_if.target  rf
);
  import qs_srt_pkg::*;

  localparam int REG_N = 2 ** $bits(reg_t);

  w_t regs [REG_N];

  // Asynchronous reads
  assign rf.rd0 = regs[rf.ra0];
  assign rf.rd1 = regs[rf.ra1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wen) begin
      regs[rf.wa] <= rf.wdata;
    end
  end

endmodule

`default_nettype wire

//--- source/qs_srt_stack.sv
////////////////////
// Hardware stack with registered head
////////////////////
`timescale 1ns/1ps
`default_nettype none

module qs_srt_stack #(
  parameter int STACK_N = qs_srt_pkg::STACK_N_DEFAULT
) (
  input  logic            clk,
  input  logic            reset,
  qs_srt_stack_if.target  st
);
  import qs_srt_pkg::*;

  localparam int PTR_W = $clog2(STACK_N + 1);
  localparam int IDX_W = (STACK_N > 1) ? $clog2(STACK_N) : 1;

  w_t               mem [STACK_N];
  w_t               head_r;
  logic [PTR_W-1:0] ptr_r;
  logic [PTR_W-1:0] below;
  logic             do_push;
  logic             do_pop;

  // Push on full and pop on empty are dropped
  assign do_push = st.vld && st.push && !st.full;
  assign do_pop  = st.vld && !st.push && !st.empty;

  // Entry under the current head
  assign below = ptr_r - PTR_W'(2);

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_r <= '0;
    end else if (do_push) begin
      ptr_r <= ptr_r + PTR_W'(1);
    end else if (do_pop) begin
      ptr_r <= ptr_r - PTR_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[ptr_r[IDX_W-1:0]] <= st.push_dat;
      head_r                <= st.push_dat;
    end else if (do_pop) begin
      head_r <= (ptr_r >= PTR_W'(2)) ? mem[below[IDX_W-1:0]] : '0;
    end
  end

  assign st.head  = head_r;
  assign st.empty = (ptr_r == '0);
  assign st.full  = (ptr_r == PTR_W'(STACK_N));

endmodule

`default_nettype wire

//--- src.f
source/qs_srt_pkg.sv
source/qs_srt_if.sv
source/qs_srt_decoder.sv
source/qs_srt_rf.sv
source/qs_srt_stack.sv
source/qs_srt_fetch.sv
source/qs_srt_execute.sv
source/qs_srt.sv
test/tb_qs_srt.sv

//--- test/tb_qs_srt.sv
////////////////////
// Sorter testbench with bank memory model, LFSR stimulus
// and reference sort
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_qs_srt;

  localparam int          MEM_N     = 256;
  localparam int          JOB_N     = 11;
  localparam int          TIMEOUT   = 20000;
  localparam int          SETTLE    = 20;
  localparam logic [15:0] LFSR_SEED = 16'd9044;

  // Bank fill kinds
  localparam int K_RAND = 0;
  localparam int K_ASC  = 1;
  localparam int K_DESC = 2;
  localparam int K_DUP  = 3;

  logic        clk;
  logic        reset;
  logic        bank_ready;
  logic [8:0]  bank_n;
  logic        bank_done;
  logic        rd_en;
  logic [7:0]  rd_addr;
  logic [15:0] rd_data;
  logic        wr_en;
  logic [7:0]  wr_addr;
  logic [15:0] wr_data;

  logic [15:0] mem     [MEM_N];
  logic [15:0] exp_mem [MEM_N];
  logic        rd_pend;
  logic [7:0]  rd_pend_addr;
  logic [8:0]  cur_n;
  logic [15:0] lfsr;
  logic        timed_out;
  int          done_cnt;
  int          err_data;
  int          err_addr;
  int          err_ctrl;
  int          err_timeout;

  qs_srt #(
    .STACK_N (qs_srt_pkg::STACK_N_DEFAULT)
  ) u_qs_srt (
    .clk        (clk),
    .reset      (reset),
    .bank_ready (bank_ready),
    .bank_n     (bank_n),
    .bank_done  (bank_done),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int nbits, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  // Insertion sort of the expected copy, words 0 to n-1
  function automatic void ref_sort(input int n);
    logic [15:0] key;
    int          j;
    for (int i = 1; i < n; i++) begin
      key = exp_mem[i];
      j   = i - 1;
      while (j >= 0) begin
        if (exp_mem[j] <= key) break;
        exp_mem[j+1] = exp_mem[j];
        j--;
      end
      exp_mem[j+1] = key;
    end
  endfunction

  task automatic fill_bank(input int n, input int kind);
    logic [15:0] v;
    for (int a = 0; a < MEM_N; a++) begin
      // Words past n carry an address pattern
      if (a >= n) begin
        mem[a] = {a[7:0], ~a[7:0]};
      end else begin
        case (kind)
          K_ASC:  mem[a] = 16'(a * 37 + 5);
          K_DESC: mem[a] = 16'((n - a) * 37 + 5);
          K_DUP: begin
            draw(1, v);
            mem[a] = v[0] ? 16'h00c3 : 16'h0c30;
          end
          default: begin
            draw(16, v);
            mem[a] = v;
          end
        endcase
      end
    end
  endtask

  // Outputs stay quiet for a number of cycles
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (bank_done === 1'b0 && rd_en === 1'b0 && wr_en === 1'b0) else begin
        err_ctrl++;
        $display("** Error at %0t: bank_done/rd_en/wr_en = %b/%b/%b, expected 0/0/0",
                 $time, bank_done, rd_en, wr_en);
      end
    end
  endtask

  task automatic run_job(input int n, input int kind);
    int cyc;
    fill_bank(n, kind);
    exp_mem = mem;
    ref_sort(n);
    done_cnt   = 0;
    cur_n      = 9'(n);
    bank_n     = 9'(n);
    bank_ready = 1'b1;
    cyc        = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (bank_done !== 1'b1 && cyc < TIMEOUT);
    if (bank_done !== 1'b1) begin
      timed_out = 1'b1;
      err_timeout++;
      $display("Timeout: no bank_done within %0d cycles for a job with n = %0d", TIMEOUT, n);
    end else begin
      bank_ready = 1'b0;
      // Window for a second, stray pulse
      repeat (SETTLE) @(negedge clk);
      assert (done_cnt == 1) else begin
        err_ctrl++;
        $display("** Error at %0t: bank_done pulses = %0d, expected 1", $time, done_cnt);
      end
    end
  endtask

  // Bank memory: read data one cycle after rd_en, writes at the falling edge
  always @(negedge clk) begin
    if (rd_pend) begin
      rd_data = mem[rd_pend_addr];
    end
    rd_pend      = (rd_en === 1'b1);
    rd_pend_addr = rd_addr;
    if (wr_en === 1'b1) begin
      mem[wr_addr] = wr_data;
    end
  end

  // Accesses stay below n
  always @(negedge clk) begin
    if (rd_en === 1'b1) begin
      assert ({1'b0, rd_addr} < cur_n) else begin
        err_addr++;
        $display("** Error at %0t: rd_addr = %0d, expected below n = %0d", $time, rd_addr, cur_n);
      end
    end
    if (wr_en === 1'b1) begin
      assert ({1'b0, wr_addr} < cur_n) else begin
        err_addr++;
        $display("** Error at %0t: wr_addr = %0d, expected below n = %0d", $time, wr_addr, cur_n);
      end
    end
  end

  // Whole bank against the reference on each done pulse
  always @(negedge clk) begin
    if (reset === 1'b0 && bank_done === 1'b1) begin
      done_cnt++;
      for (int a = 0; a < MEM_N; a++) begin
        assert (mem[a] === exp_mem[a]) else begin
          err_data++;
          $display("** Error at %0t: mem[%0d] = %h, expected %h", $time, a, mem[a], exp_mem[a]);
        end
      end
    end
  end

  initial begin
    int          n;
    int          kind;
    logic [15:0] v;
    clk          = 1'b0;
    reset        = 1'b1;
    bank_ready   = 1'b0;
    bank_n       = '0;
    rd_data      = '0;
    rd_pend      = 1'b0;
    rd_pend_addr = '0;
    cur_n        = '0;
    lfsr         = LFSR_SEED;
    timed_out    = 1'b0;
    done_cnt     = 0;
    err_data     = 0;
    err_addr     = 0;
    err_ctrl     = 0;
    err_timeout  = 0;
    for (int a = 0; a < MEM_N; a++) begin
      mem[a]     = '0;
      exp_mem[a] = '0;
    end

    // Reset for 8 cycles, then 50 idle cycles without a bank
    check_idle(8);
    reset = 1'b0;
    check_idle(50);

    for (int j = 0; j < JOB_N && !timed_out; j++) begin
      case (j)
        0: begin n = 12; kind = K_RAND; end
        1: begin n = 12; kind = K_ASC;  end
        2: begin n = 12; kind = K_DESC; end
        3: begin n = 12; kind = K_DUP;  end
        4: begin n = 1;  kind = K_RAND; end
        5: begin n = 2;  kind = K_RAND; end
        // Back-to-back jobs, n from 1 to 16
        default: begin
          draw(4, v);
          n    = int'(v[3:0]) + 1;
          kind = K_RAND;
        end
      endcase
      run_job(n, kind);
    end

    $display("Errors: data %0d, address %0d, control %0d, timeout %0d",
             err_data, err_addr, err_ctrl, err_timeout);
    if (err_data + err_addr + err_ctrl + err_timeout == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
